// ==== logic/axi_lite_pkg.sv ====
// AXI4-Lite channel types
package axi_lite_pkg;

    // ------------------------------------------------------------------------
    // Widths of the AXI4-Lite address channel fields
    // ------------------------------------------------------------------------

    // Byte address width of the bus
    localparam int AXI_ADDR_W = 32;

    // Protection attribute width (privileged, non-secure, instruction)
    localparam int AXI_PROT_W = 3;

    // Accesses are 32-bit aligned, so this many low address bits are always zero
    localparam int AXI_ADDR_LSB = 2;

    // ------------------------------------------------------------------------
    // Field types
    // ------------------------------------------------------------------------

    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;

    typedef logic [AXI_PROT_W-1:0] axi_prot_t;

    // Write address channel payload, 35 bits in all
    // Valid and ready travel beside it as plain signals
    typedef struct packed {
        axi_addr_t addr;
        axi_prot_t prot;
    } aw_chan_t;

endpackage

// ==== logic/mem_pkg.sv ====
// Register file geometry and pointers
package mem_pkg;

    // ------------------------------------------------------------------------
    // Register file geometry
    // ------------------------------------------------------------------------

    // Number of entries held by the FIFO
    localparam int RF_DEPTH = 8;

    // Row index width, and the pointer width with one extra wrap bit
    localparam int RF_ADDR_W = $clog2(RF_DEPTH);
    localparam int PTR_W     = RF_ADDR_W + 1;

    typedef logic [RF_ADDR_W-1:0] rf_addr_t;

    // FIFO pointer, used both in binary and in Gray code
    typedef logic [PTR_W-1:0] ptr_t;

    // Stored entry layout, the word address sits above the protection bits
    typedef struct packed {
        logic [29:0] word_addr;
        logic [2:0]  prot;
    } rf_entry_t;

    // One row of the register file as a flat 33-bit word
    typedef logic [$bits(rf_entry_t)-1:0] rf_word_t;

    // Binary to Gray conversion for pointers that cross clock domains
    function automatic ptr_t bin_to_gray(ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

endpackage

// ==== logic/reset_sync.sv ====
// Reset synchronizer
module reset_sync #(
    parameter int SYNC_STAGES = 2
) (
    input  logic clk,
    input  logic rst,
    output logic rst_sync
);

    // ------------------------------------------------------------------------
    // Shift chain
    // ------------------------------------------------------------------------

    // One flop per stage, the raw reset enters at index zero
    logic [SYNC_STAGES-1:0] chain_q;

    // The raw rst is already synchronous to some clock, so the chain simply
    // samples it and both edges of the reset take SYNC_STAGES edges to come out
    always_ff @(posedge clk) begin
        chain_q[0] <= rst;
        for (int i = 1; i < SYNC_STAGES; i++) begin
            chain_q[i] <= chain_q[i-1];
        end
    end

    // Last stage drives the domain reset
    assign rst_sync = chain_q[SYNC_STAGES-1];

endmodule

// ==== logic/gray_ptr_sync.sv ====
// Gray pointer synchronizer
module gray_ptr_sync #(
    parameter int SYNC_STAGES = 2
) (
    input  logic          clk,
    input  logic          rst,
    input  mem_pkg::ptr_t ptr_gray_in,
    output mem_pkg::ptr_t ptr_gray_out
);

    // ------------------------------------------------------------------------
    // Synchronizer chain
    // ------------------------------------------------------------------------

    // Stage zero samples the foreign pointer and may go metastable
    mem_pkg::ptr_t sync_q [SYNC_STAGES];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= ptr_gray_in;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    // The settled copy leaves from the last stage
    assign ptr_gray_out = sync_q[SYNC_STAGES-1];

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    // Only one bit of the Gray pointer may move between two samples here,
    // otherwise the first stage could capture a pointer that never existed
    // The domain reset is unknown until the raw reset has passed its chain
    a_one_bit_step : assert property (@(posedge clk) disable iff (rst !== 1'b0)
        $countones(ptr_gray_in ^ $past(ptr_gray_in)) <= 1)
        else $error("gray_ptr_sync: more than one pointer bit changed");

endmodule

// ==== logic/aw_rf_8x33.sv ====
// Two-clock AW register file
module aw_rf_8x33 #(
    parameter int SYNC_STAGES = 2
) (
    // Write port
    input  logic              wclk,
    input  logic              we,
    input  mem_pkg::rf_addr_t waddr,
    input  mem_pkg::rf_word_t wdata,

    // Read port
    input  logic              rclk,
    input  logic              re,
    input  mem_pkg::rf_addr_t raddr,
    output mem_pkg::rf_word_t rdata,

    // Raw reset, brought into the read domain below
    input  logic              rst
);

    // ------------------------------------------------------------------------
    // Storage and read-side reset
    // ------------------------------------------------------------------------

    // Eight rows of 33 bits, no reset on the array itself
    mem_pkg::rf_word_t mem_q [mem_pkg::RF_DEPTH];

    // Read-side reset that clears the output register
    logic rrst;

    // The array keeps its own reset synchronizer on the read clock
    reset_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_rrst_sync (
        .clk      (rclk),
        .rst      (rst),
        .rst_sync (rrst)
    );

    // ------------------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------------------

    // A row is written on the wclk edge with we high
    always_ff @(posedge wclk) begin
        if (we) begin
            mem_q[waddr] <= wdata;
        end
    end

    // ------------------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------------------

    // Registered read data
    // It holds its value until the next re
    always_ff @(posedge rclk) begin
        if (rrst) begin
            rdata <= '0;
        end else if (re) begin
            rdata <= mem_q[raddr];
        end
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    // A write with an unknown row would corrupt some entry in the array
    a_waddr_known : assert property (@(posedge wclk) disable iff (rst)
        we |-> !$isunknown(waddr))
        else $error("aw_rf_8x33: write with unknown waddr");

    // Reads likewise need a known row once the read domain is out of reset
    a_raddr_known : assert property (@(posedge rclk) disable iff (rrst)
        re |-> !$isunknown(raddr))
        else $error("aw_rf_8x33: read with unknown raddr");

endmodule

// ==== logic/aw_fifo_wr_ctrl.sv ====
// AW FIFO write controller
module aw_fifo_wr_ctrl (
    input  logic                  wclk,
    input  logic                  rst,

    // AXI4-Lite slave side
    input  axi_lite_pkg::aw_chan_t s_aw,
    input  logic                  s_awvalid,
    output logic                  s_awready,

    // Register file write port
    output logic                  we,
    output mem_pkg::rf_addr_t     waddr,
    output mem_pkg::rf_word_t     wdata,

    // Pointers crossing to and from the read domain
    output mem_pkg::ptr_t         wr_ptr_gray,
    input  mem_pkg::ptr_t         rd_ptr_gray_sync
);

    localparam int PTR_W = mem_pkg::PTR_W;

    mem_pkg::ptr_t     wr_bin_q;
    mem_pkg::ptr_t     wr_bin_next;
    mem_pkg::ptr_t     wr_gray_next;
    mem_pkg::ptr_t     full_match;
    mem_pkg::rf_entry_t entry;
    logic              full_q;
    logic              xfer;

    // ------------------------------------------------------------------------
    // Handshake and payload packing
    // ------------------------------------------------------------------------

    // Ready comes straight from the registered full flag
    assign s_awready = !full_q;
    assign xfer      = s_awvalid && s_awready;

    // Drop the two byte offset bits, the access is always word aligned
    assign entry.word_addr = s_aw.addr[axi_lite_pkg::AXI_ADDR_W-1:axi_lite_pkg::AXI_ADDR_LSB];
    assign entry.prot      = s_aw.prot;

    assign we    = xfer;
    assign waddr = wr_bin_q[mem_pkg::RF_ADDR_W-1:0];
    assign wdata = entry;

    // ------------------------------------------------------------------------
    // Pointers and full flag
    // ------------------------------------------------------------------------

    assign wr_bin_next  = wr_bin_q + mem_pkg::ptr_t'(xfer);
    assign wr_gray_next = mem_pkg::bin_to_gray(wr_bin_next);

    // In Gray code the pointers are one lap apart when the top two bits differ
    assign full_match = {~rd_ptr_gray_sync[PTR_W-1:PTR_W-2], rd_ptr_gray_sync[PTR_W-3:0]};

    always_ff @(posedge wclk) begin
        if (rst) begin
            wr_bin_q    <= '0;
            wr_ptr_gray <= '0;
            full_q      <= 1'b0;
        end else begin
            wr_bin_q    <= wr_bin_next;
            wr_ptr_gray <= wr_gray_next;
            full_q      <= (wr_gray_next == full_match);
        end
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    // Checked against the raw pointers rather than the flag
    a_no_write_full : assert property (@(posedge wclk) disable iff (rst)
        we |-> (wr_ptr_gray != full_match))
        else $error("aw_fifo_wr_ctrl: write while FIFO full");

endmodule

// ==== logic/aw_fifo_rd_ctrl.sv ====
// AW FIFO read controller
module aw_fifo_rd_ctrl (
    input  logic                   rclk,
    input  logic                   rst,

    // Register file read port
    output logic                   re,
    output mem_pkg::rf_addr_t      raddr,
    input  mem_pkg::rf_word_t      rdata,

    // Pointers crossing to and from the write domain
    output mem_pkg::ptr_t          rd_ptr_gray,
    input  mem_pkg::ptr_t          wr_ptr_gray_sync,

    // AXI4-Lite master side
    output axi_lite_pkg::aw_chan_t m_aw,
    output logic                   m_awvalid,
    input  logic                   m_awready
);

    // How many words sit in the output register and the skid slot
    typedef enum logic [1:0] {
        OUT_EMPTY = 2'd0,
        OUT_ONE   = 2'd1,
        OUT_TWO   = 2'd2
    } out_state_t;

    out_state_t         state_q;
    out_state_t         state_d;
    mem_pkg::ptr_t      rd_bin_q;
    mem_pkg::ptr_t      rd_bin_next;
    mem_pkg::rf_word_t  out_q;
    mem_pkg::rf_word_t  skid_q;
    mem_pkg::rf_entry_t out_entry;
    logic               fetch_q;
    logic               empty;
    logic               pop;
    logic               room;
    logic               load_out;
    logic               out_from_skid;
    logic               load_skid;

    // ------------------------------------------------------------------------
    // Fetch side
    // ------------------------------------------------------------------------

    assign empty       = (rd_ptr_gray == wr_ptr_gray_sync);
    assign pop         = m_awvalid && m_awready;
    assign re          = !empty && room;
    assign raddr       = rd_bin_q[mem_pkg::RF_ADDR_W-1:0];
    assign rd_bin_next = rd_bin_q + mem_pkg::ptr_t'(re);

    // ------------------------------------------------------------------------
    // Output slot FSM
    // ------------------------------------------------------------------------

    // Two slots exist, so held words plus the fetch in flight stay at two
    always_comb begin
        state_d       = state_q;
        room          = 1'b0;
        load_out      = 1'b0;
        out_from_skid = 1'b0;
        load_skid     = 1'b0;
        case (state_q)
            OUT_EMPTY: begin
                room     = 1'b1;
                load_out = fetch_q;
                if (fetch_q) begin
                    state_d = OUT_ONE;
                end
            end
            OUT_ONE: begin
                room = !fetch_q || pop;
                if (fetch_q && pop) begin
                    load_out = 1'b1;
                end else if (fetch_q) begin
                    // The slave stalls, the returning word parks in the skid slot
                    load_skid = 1'b1;
                    state_d   = OUT_TWO;
                end else if (pop) begin
                    state_d = OUT_EMPTY;
                end
            end
            OUT_TWO: begin
                // No fetch can be in flight here
                room = pop;
                if (pop) begin
                    load_out      = 1'b1;
                    out_from_skid = 1'b1;
                    state_d       = OUT_ONE;
                end
            end
            default: begin
                state_d = OUT_EMPTY;
            end
        endcase
    end

    always_ff @(posedge rclk) begin
        if (rst) begin
            state_q     <= OUT_EMPTY;
            fetch_q     <= 1'b0;
            rd_bin_q    <= '0;
            rd_ptr_gray <= '0;
        end else begin
            state_q     <= state_d;
            fetch_q     <= re;
            rd_bin_q    <= rd_bin_next;
            rd_ptr_gray <= mem_pkg::bin_to_gray(rd_bin_next);
        end
    end

    // Payload registers
    always_ff @(posedge rclk) begin
        if (load_out) begin
            out_q <= out_from_skid ? skid_q : rdata;
        end
        if (load_skid) begin
            skid_q <= rdata;
        end
    end

    // Unpack the entry and put back the zero byte offset
    assign out_entry = mem_pkg::rf_entry_t'(out_q);
    assign m_aw.addr = {out_entry.word_addr, {axi_lite_pkg::AXI_ADDR_LSB{1'b0}}};
    assign m_aw.prot = out_entry.prot;
    assign m_awvalid = (state_q != OUT_EMPTY);

    // A stalled transfer keeps valid and payload until it completes
    a_aw_stable : assert property (@(posedge rclk) disable iff (rst)
        m_awvalid && !m_awready |=> m_awvalid && $stable(m_aw))
        else $error("aw_fifo_rd_ctrl: m_aw changed while stalled");

endmodule

// ==== logic/aw_cdc_buffer.sv ====
// AXI4-Lite AW clock crossing buffer
module aw_cdc_buffer #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                   wclk,
    input  logic                   rclk,
    input  logic                   rst,

    // Slave side on wclk
    input  axi_lite_pkg::aw_chan_t s_aw,
    input  logic                   s_awvalid,
    output logic                   s_awready,

    // Master side on rclk
    output axi_lite_pkg::aw_chan_t m_aw,
    output logic                   m_awvalid,
    input  logic                   m_awready
);

    logic              wrst;
    logic              rrst;
    logic              we;
    logic              re;
    mem_pkg::rf_addr_t waddr;
    mem_pkg::rf_addr_t raddr;
    mem_pkg::rf_word_t wdata;
    mem_pkg::rf_word_t rdata;
    mem_pkg::ptr_t     wr_ptr_gray;
    mem_pkg::ptr_t     wr_ptr_gray_sync;
    mem_pkg::ptr_t     rd_ptr_gray;
    mem_pkg::ptr_t     rd_ptr_gray_sync;

    // ------------------------------------------------------------------------
    // Per-domain resets
    // ------------------------------------------------------------------------

    reset_sync #(.SYNC_STAGES(SYNC_STAGES)) u_wrst_sync (
        .clk (wclk), .rst (rst), .rst_sync (wrst)
    );

    reset_sync #(.SYNC_STAGES(SYNC_STAGES)) u_rrst_sync (
        .clk (rclk), .rst (rst), .rst_sync (rrst)
    );

    // ------------------------------------------------------------------------
    // Pointer crossings
    // ------------------------------------------------------------------------

    // Write pointer into the read domain for the empty test
    gray_ptr_sync #(.SYNC_STAGES(SYNC_STAGES)) u_wr_ptr_sync (
        .clk (rclk), .rst (rrst), .ptr_gray_in (wr_ptr_gray), .ptr_gray_out (wr_ptr_gray_sync)
    );

    // Read pointer back into the write domain for the full test
    gray_ptr_sync #(.SYNC_STAGES(SYNC_STAGES)) u_rd_ptr_sync (
        .clk (wclk), .rst (wrst), .ptr_gray_in (rd_ptr_gray), .ptr_gray_out (rd_ptr_gray_sync)
    );

    // ------------------------------------------------------------------------
    // Controllers and storage
    // ------------------------------------------------------------------------

    aw_fifo_wr_ctrl u_wr_ctrl (
        .wclk (wclk), .rst (wrst),
        .s_aw (s_aw), .s_awvalid (s_awvalid), .s_awready (s_awready),
        .we (we), .waddr (waddr), .wdata (wdata),
        .wr_ptr_gray (wr_ptr_gray), .rd_ptr_gray_sync (rd_ptr_gray_sync)
    );

    aw_rf_8x33 #(.SYNC_STAGES(SYNC_STAGES)) u_rf (
        .wclk (wclk), .we (we), .waddr (waddr), .wdata (wdata),
        .rclk (rclk), .re (re), .raddr (raddr), .rdata (rdata),
        .rst  (rst)
    );

    aw_fifo_rd_ctrl u_rd_ctrl (
        .rclk (rclk), .rst (rrst),
        .re (re), .raddr (raddr), .rdata (rdata),
        .rd_ptr_gray (rd_ptr_gray), .wr_ptr_gray_sync (wr_ptr_gray_sync),
        .m_aw (m_aw), .m_awvalid (m_awvalid), .m_awready (m_awready)
    );

endmodule

// ==== bench/tb_clk_gen.sv ====
// Testbench clock generator
module tb_clk_gen #(
    parameter int PERIOD = 100,
    parameter int PHASE  = 0
) (
    output logic clk
);

    // The clock starts low and its first rising edge comes PHASE plus half a
    // period after time zero
    initial begin
        clk = 1'b0;
        #(PHASE);
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

// ==== bench/aw_cdc_buffer_tb.sv ====
// AW clock crossing buffer testbench
module aw_cdc_buffer_tb;

    // Held entries: eight FIFO rows plus the output register and skid slot
    localparam int CAPACITY    = mem_pkg::RF_DEPTH + 2;
    localparam int N_RANDOM    = 200;
    localparam int DRAIN_LIMIT = 20;
    localparam int TIMEOUT     = 300 * 20 * 100;

    logic                   wclk;
    logic                   rclk;
    logic                   rst;
    axi_lite_pkg::aw_chan_t s_aw;
    logic                   s_awvalid;
    logic                   s_awready;
    axi_lite_pkg::aw_chan_t m_aw;
    logic                   m_awvalid;
    logic                   m_awready;

    // Scoreboard state and the head entry that the checks compare against
    axi_lite_pkg::aw_chan_t sb_q [$];
    axi_lite_pkg::aw_chan_t head_aw = '0;
    axi_lite_pkg::aw_chan_t m_aw_prev = '0;
    int                     sb_count = 0;
    int                     pushed = 0;
    int                     checked = 0;
    int                     errors = 0;
    int                     rd_mode = 0;
    integer                 seed = 25;
    logic                   fill_check;
    logic                   drain_check;

    // ------------------------------------------------------------------------
    // Clocks and DUT
    // ------------------------------------------------------------------------

    // Same period on both sides, the read clock is shifted so no edges line up
    tb_clk_gen #(.PERIOD(100), .PHASE(0))  u_wclk_gen (.clk(wclk));
    tb_clk_gen #(.PERIOD(100), .PHASE(37)) u_rclk_gen (.clk(rclk));

    aw_cdc_buffer #(
        .SYNC_STAGES (2)
    ) u_dut (
        .wclk      (wclk),
        .rclk      (rclk),
        .rst       (rst),
        .s_aw      (s_aw),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .m_aw      (m_aw),
        .m_awvalid (m_awvalid),
        .m_awready (m_awready)
    );

    // ------------------------------------------------------------------------
    // Scoreboard
    // ------------------------------------------------------------------------

    // Keeps the head copy and the count in step with the queue
    task automatic update_head();
        sb_count = sb_q.size();
        if (sb_q.size() > 0) begin
            head_aw = sb_q[0];
        end
    endtask

    // Every accepted request on the slave side is recorded in order
    always @(posedge wclk) begin
        if (!rst && s_awvalid && s_awready) begin
            sb_q.push_back(s_aw);
            pushed++;
            update_head();
        end
    end

    // Every master side transfer retires the oldest entry
    always @(posedge rclk) begin
        m_aw_prev <= m_aw;
        if (!rst && m_awvalid && m_awready) begin
            if (sb_q.size() > 0) begin
                sb_q.delete(0);
            end
            checked++;
            update_head();
        end
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    // Right after reset the buffer is empty and ready
    a_ready_after_reset : assert property (@(posedge wclk) $fell(rst) |-> s_awready)
        else begin
            errors++;
            $display("CHECK FAILED t=%0t s_awready expected 1 actual %0b",
                     $time, $sampled(s_awready));
        end

    a_idle_after_reset : assert property (@(posedge wclk) $fell(rst) |-> !m_awvalid)
        else begin
            errors++;
            $display("CHECK FAILED t=%0t m_awvalid expected 0 actual %0b",
                     $time, $sampled(m_awvalid));
        end

    a_head_present : assert property (@(posedge rclk) disable iff (rst)
        m_awvalid && m_awready |-> sb_count > 0)
        else begin
            errors++;
            $display("Output transfer at t=%0t with no request outstanding", $time);
        end

    // Output carries the same prot and the word aligned address
    a_prot_match : assert property (@(posedge rclk) disable iff (rst)
        m_awvalid && m_awready && sb_count > 0 |-> m_aw.prot == head_aw.prot)
        else begin
            errors++;
            $display("CHECK FAILED t=%0t m_aw.prot expected %h actual %h",
                     $time, $sampled(head_aw.prot), $sampled(m_aw.prot));
        end

    a_addr_match : assert property (@(posedge rclk) disable iff (rst)
        m_awvalid && m_awready && sb_count > 0 |->
        m_aw.addr == {head_aw.addr[31:2], 2'b00})
        else begin
            errors++;
            $display("CHECK FAILED t=%0t m_aw.addr expected %h actual %h", $time,
                     {$sampled(head_aw.addr[31:2]), 2'b00}, $sampled(m_aw.addr));
        end

    // A stalled output keeps valid high and its payload frozen
    a_stall_valid : assert property (@(posedge rclk) disable iff (rst)
        m_awvalid && !m_awready |=> m_awvalid)
        else begin
            errors++;
            $display("CHECK FAILED t=%0t m_awvalid expected 1 actual 0", $time);
        end

    a_stall_hold : assert property (@(posedge rclk) disable iff (rst)
        m_awvalid && !m_awready |=> m_aw == m_aw_prev)
        else begin
            errors++;
            $display("CHECK FAILED t=%0t m_aw expected %h actual %h",
                     $time, $sampled(m_aw_prev), $sampled(m_aw));
        end

    a_outstanding : assert property (@(posedge wclk) disable iff (rst)
        sb_count <= CAPACITY)
        else begin
            errors++;
            $display("More than %0d requests outstanding at t=%0t (%0d)",
                     CAPACITY, $time, $sampled(sb_count));
        end

    // With the master stalled the buffer fills to capacity and closes
    a_fill_count : assert property (@(posedge wclk) fill_check |-> sb_count == CAPACITY)
        else begin
            errors++;
            $display("CHECK FAILED t=%0t sb_count expected %0d actual %0d",
                     $time, CAPACITY, $sampled(sb_count));
        end

    a_fill_ready : assert property (@(posedge wclk) fill_check |-> !s_awready)
        else begin
            errors++;
            $display("CHECK FAILED t=%0t s_awready expected 0 actual %0b",
                     $time, $sampled(s_awready));
        end

    a_drained : assert property (@(posedge rclk) drain_check |-> sb_count == 0)
        else begin
            errors++;
            $display("Buffer not drained at t=%0t, %0d requests still outstanding",
                     $time, $sampled(sb_count));
        end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    // One wclk cycle on the slave side, a raised valid holds until accepted
    task automatic step_slave(input bit rand_valid, input int limit);
        logic took;
        @(posedge wclk);
        took = s_awvalid && s_awready;
        #10;
        if (!s_awvalid || took) begin
            if (pushed < limit && (!rand_valid || ($random(seed) & 1))) begin
                s_awvalid = 1'b1;
                s_aw.addr = $random(seed);
                s_aw.prot = $random(seed);
            end else begin
                s_awvalid = 1'b0;
            end
        end
    endtask

    // Master side ready, held low, random or held high
    initial begin
        m_awready = 1'b0;
        forever begin
            @(posedge rclk);
            #10;
            case (rd_mode)
                0:       m_awready = 1'b0;
                1:       m_awready = $random(seed) & 1;
                default: m_awready = 1'b1;
            endcase
        end
    end

    initial begin
        int target;
        rst         = 1'b1;
        s_aw        = '0;
        s_awvalid   = 1'b0;
        fill_check  = 1'b0;
        drain_check = 1'b0;
        repeat (8) @(posedge wclk);
        #10 rst = 1'b0;
        // Give both synchronized resets time to release
        repeat (4) @(posedge wclk);

        // Back-pressure from reset, valid held high throughout
        repeat (40) step_slave(1'b0, 1000);
        fill_check = 1'b1;
        step_slave(1'b0, 1000);
        fill_check = 1'b0;

        // Random traffic on both sides
        rd_mode = 1;
        target  = pushed + N_RANDOM;
        while (pushed < target || s_awvalid) begin
            step_slave(1'b1, target);
        end

        // Stop the stimulus and let the master side drain
        rd_mode = 2;
        repeat (DRAIN_LIMIT) @(posedge rclk);
        #10 drain_check = 1'b1;
        @(posedge rclk);
        #10 drain_check = 1'b0;

        $display("Errors: %0d, requests accepted: %0d, transfers checked: %0d",
                 errors, pushed, checked);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // ------------------------------------------------------------------------
    // Watchdog
    // ------------------------------------------------------------------------

    initial begin
        #(TIMEOUT);
        $display("Watchdog timeout after %0d time units, the run did not complete",
                 TIMEOUT);
        $display("Errors: %0d, requests accepted: %0d, transfers checked: %0d",
                 errors, pushed, checked);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== aw_cdc_buffer.f ====
logic/axi_lite_pkg.sv
logic/mem_pkg.sv
logic/reset_sync.sv
logic/gray_ptr_sync.sv
logic/aw_rf_8x33.sv
logic/aw_fifo_wr_ctrl.sv
logic/aw_fifo_rd_ctrl.sv
logic/aw_cdc_buffer.sv
bench/tb_clk_gen.sv
bench/aw_cdc_buffer_tb.sv

// ==== Bender.yml ====
package:
  name: aw_cdc_buffer

sources:
  # Packages come first, the RTL top level last
  - logic/axi_lite_pkg.sv
  - logic/mem_pkg.sv
  - logic/reset_sync.sv
  - logic/gray_ptr_sync.sv
  - logic/aw_rf_8x33.sv
  - logic/aw_fifo_wr_ctrl.sv
  - logic/aw_fifo_rd_ctrl.sv
  - logic/aw_cdc_buffer.sv

  # Testbench sources
  - target: test
    files:
      - bench/tb_clk_gen.sv
      - bench/aw_cdc_buffer_tb.sv
